// File: sim.f
+incdir+include
rtl/aes_pkg.sv
rtl/aes_ctrl_if.sv
rtl/aes_sbox.sv
rtl/aes_round.sv
rtl/aes_key_step.sv
rtl/aes_round_ctrl.sv
rtl/aes_state_regs.sv
rtl/aes_enc_top.sv
tb/tb_aes_enc.sv

// File: Bender.yml
package:
  name: aes_enc

sources:
  - rtl/aes_pkg.sv
  - rtl/aes_ctrl_if.sv
  - rtl/aes_sbox.sv
  - rtl/aes_round.sv
  - rtl/aes_key_step.sv
  - rtl/aes_round_ctrl.sv
  - rtl/aes_state_regs.sv
  - rtl/aes_enc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_aes_enc.sv

// File: include/aes_tb_ref.svh
// ----------------------------------------------------------
// Software AES-128 encryption model for the testbench
// Byte-table S-box, FIPS-197 key expansion and round order
// Included inside the testbench module body
// ----------------------------------------------------------
`ifndef AES_TB_REF_SVH
`define AES_TB_REF_SVH

// FIPS-197 S-box, entry 0 in the MSBs
localparam logic [0:255][7:0] SBOX_TABLE = {
   128'h637c777bf26b6fc53001672bfed7ab76,
   128'hca82c97dfa5947f0add4a2af9ca472c0,
   128'hb7fd9326363ff7cc34a5e5f171d83115,
   128'h04c723c31896059a071280e2eb27b275,
   128'h09832c1a1b6e5aa0523bd6b329e32f84,
   128'h53d100ed20fcb15b6acbbe394a4c58cf,
   128'hd0efaafb434d338545f9027f503c9fa8,
   128'h51a3408f929d38f5bcb6da2110fff3d2,
   128'hcd0c13ec5f974417c4a77e3d645d1973,
   128'h60814fdc222a908846eeb814de5e0bdb,
   128'he0323a0a4906245cc2d3ac629195e479,
   128'he7c8376d8dd54ea96c56f4ea657aae08,
   128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
   128'h703eb5664803f60e613557b986c11d9e,
   128'he1f8981169d98e949b1e87e9ce5528df,
   128'h8ca1890dbfe6426841992d0fb054bb16
};

// Multiply by 2 modulo x^8+x^4+x^3+x+1
function automatic logic [7:0] gf_double(input logic [7:0] b);
   return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// Whole block, byte 0 is the MSB, byte 4*c+r is row r of column c
function automatic logic [127:0] encrypt_model(input logic [127:0] key,
                                               input logic [127:0] pt);
   logic [7:0]   s [16];                 // State
   logic [7:0]   t [16];                 // After SubBytes and ShiftRows
   logic [7:0]   k [16];                 // Current round key
   logic [7:0]   rc;
   logic [127:0] res;
   for (int i = 0; i < 16; i++) begin
      k[i] = key[127-8*i -: 8];
      s[i] = pt[127-8*i -: 8] ^ k[i];    // Initial AddRoundKey
   end
   rc = 8'h01;
   for (int rnd = 1; rnd <= 10; rnd++) begin
      k[0] = k[0] ^ SBOX_TABLE[k[13]] ^ rc;   // RotWord, SubWord, Rcon
      k[1] = k[1] ^ SBOX_TABLE[k[14]];
      k[2] = k[2] ^ SBOX_TABLE[k[15]];
      k[3] = k[3] ^ SBOX_TABLE[k[12]];
      for (int i = 4; i < 16; i++) begin
         k[i] = k[i] ^ k[i-4];
      end
      rc = gf_double(rc);
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            t[4*c+r] = SBOX_TABLE[s[4*((c+r)%4)+r]];
         end
      end
      for (int c = 0; c < 4; c++) begin
         if (rnd < 10) begin             // No MixColumns in last round
            s[4*c]   = gf_double(t[4*c]) ^ gf_double(t[4*c+1]) ^ t[4*c+1]
                       ^ t[4*c+2] ^ t[4*c+3];
            s[4*c+1] = t[4*c] ^ gf_double(t[4*c+1]) ^ gf_double(t[4*c+2])
                       ^ t[4*c+2] ^ t[4*c+3];
            s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gf_double(t[4*c+2])
                       ^ gf_double(t[4*c+3]) ^ t[4*c+3];
            s[4*c+3] = gf_double(t[4*c]) ^ t[4*c] ^ t[4*c+1] ^ t[4*c+2]
                       ^ gf_double(t[4*c+3]);
         end else begin
            for (int r = 0; r < 4; r++) begin
               s[4*c+r] = t[4*c+r];
            end
         end
      end
      for (int i = 0; i < 16; i++) begin
         s[i] = s[i] ^ k[i];
      end
   end
   for (int i = 0; i < 16; i++) begin
      res[127-8*i -: 8] = s[i];
   end
   return res;
endfunction

`endif

// File: tb/tb_aes_enc.sv
// ----------------------------------------------------------
// Testbench for the iterative AES-128 core
// Known vectors, random blocks, back-to-back and en drops
// Results checked against a software model on every dvld
// ----------------------------------------------------------
module tb_aes_enc;
   import aes_pkg::*;

   `include "aes_tb_ref.svh"

   localparam int BLOCK_TIMEOUT = 100;   // Cycles from drdy to dvld
   localparam int IDLE_TIMEOUT  = 20;    // Cycles for bsy to fall

   logic       CLK;
   logic       rst;
   logic       en;
   logic       krdy;
   logic       drdy;
   aes_block_t kin;
   aes_block_t din;
   aes_block_t dout;
   logic       kvld;
   logic       dvld;
   logic       bsy;

   integer     seed = 32'h6472_f2db;
   aes_block_t exp_q [$];                // Expected ciphertexts in order
   string      name_q [$];
   int         n_issued  = 0;
   int         n_checked = 0;

   aes_enc_top dut_i (
      .CLK (CLK), .rst (rst), .en (en), .krdy (krdy), .drdy (drdy),
      .kin (kin), .din (din), .dout (dout), .kvld (kvld), .dvld (dvld), .bsy (bsy)
   );

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // ----------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at first error");
   endtask

   function automatic aes_block_t rand_block();
      aes_block_t b;
      for (int i = 0; i < 4; i++) begin
         b[32*i +: 32] = $random(seed);
      end
      return b;
   endfunction

   function automatic logic next_en();
      return ($random(seed) & 3) != 0;   // Low about one cycle in four
   endfunction

   task automatic load_key(input string name, input aes_block_t k);
      @(posedge CLK);
      en   <= 1'b1;
      kin  <= k;
      krdy <= 1'b1;
      @(posedge CLK);                    // Edge that samples krdy
      krdy <= 1'b0;
      @(negedge CLK);
      assert (kvld === 1'b1) else abort_run($sformatf("FAIL %s: kvld expected 1 actual %b",
                                                        name, kvld));
      @(negedge CLK);
      assert (kvld === 1'b0) else abort_run($sformatf("FAIL %s: kvld expected 0 actual %b",
                                                        name, kvld));
   endtask

   task automatic wait_idle(input string name);
      int waited;
      waited = 0;
      @(negedge CLK);
      while (bsy) begin
         if (waited >= IDLE_TIMEOUT) abort_run($sformatf("bsy never fell after %s", name));
         @(negedge CLK);
         waited++;
      end
   endtask

   // Issue one block, count enabled edges up to dvld
   task automatic run_block(input string name, input aes_block_t pt, input aes_block_t want,
                            input logic drop_en);
      int edges;
      int waited;
      @(posedge CLK);
      en   <= 1'b1;
      din  <= pt;
      drdy <= 1'b1;
      exp_q.push_back(want);
      name_q.push_back(name);
      n_issued++;
      @(posedge CLK);                    // Edge that samples drdy
      drdy <= 1'b0;
      if (drop_en) en <= next_en();
      edges  = 0;
      waited = 0;
      @(negedge CLK);
      while (!dvld) begin
         assert (bsy) else abort_run($sformatf("bsy dropped during the rounds of %s", name));
         if (waited >= BLOCK_TIMEOUT) abort_run($sformatf("dvld never arrived for %s", name));
         if (en) edges++;                // Next rising edge is enabled
         @(posedge CLK);
         if (drop_en) en <= next_en();
         @(negedge CLK);
         waited++;
      end
      assert (edges == N_ROUNDS) else abort_run($sformatf(
         "FAIL %s: enabled edges to dvld expected %0d actual %0d", name, N_ROUNDS, edges));
      assert (bsy) else abort_run($sformatf("bsy low in the dvld cycle of %s", name));
      @(posedge CLK);
      en <= 1'b1;                        // Let the dvld cycle end
      wait_idle(name);
   endtask

   // ----------------------------------------------------------
   // Response checker
   // ----------------------------------------------------------
   initial begin : compare_proc
      aes_block_t want;
      string      nm;
      forever begin
         @(negedge CLK);
         if (!rst && dvld && en) begin   // Last cycle of the pulse
            assert (exp_q.size() > 0) else abort_run("dvld pulsed with no block pending");
            want = exp_q.pop_front();
            nm   = name_q.pop_front();
            assert (dout === want) else abort_run($sformatf(
               "FAIL %s: expected %h actual %h", nm, want, dout));
            n_checked++;
         end
      end
   end

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------
   initial begin : stimulus
      aes_block_t k;
      aes_block_t pt;
      rst  = 1'b1;
      en   = 1'b1;
      krdy = 1'b0;
      drdy = 1'b0;
      kin  = '0;
      din  = '0;
      repeat (10) @(posedge CLK);
      rst <= 1'b0;
      @(negedge CLK);
      assert (dvld === 1'b0) else abort_run($sformatf(
         "FAIL reset: dvld expected 0 actual %b", dvld));
      assert (kvld === 1'b0) else abort_run($sformatf(
         "FAIL reset: kvld expected 0 actual %b", kvld));
      assert (bsy === 1'b0) else abort_run($sformatf(
         "FAIL reset: bsy expected 0 actual %b", bsy));
      assert (dout === '0) else abort_run($sformatf(
         "FAIL reset: dout expected 0 actual %h", dout));

      // FIPS-197 appendix C.1 and appendix B
      k  = 128'h000102030405060708090a0b0c0d0e0f;
      pt = 128'h00112233445566778899aabbccddeeff;
      assert (encrypt_model(k, pt) == 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
         else abort_run("software model disagrees with the FIPS-197 vector");
      load_key("fips_c1", k);
      run_block("fips_c1", pt, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0);
      load_key("fips_b", 128'h2b7e151628aed2a6abf7158809cf4f3c);
      run_block("fips_b", 128'h3243f6a8885a308d313198a2e0370734,
                128'h3925841d02dc09fbdc118597196a0b32, 1'b0);

      for (int i = 0; i < 20; i++) begin
         k  = rand_block();
         pt = rand_block();
         load_key($sformatf("random_%0d", i), k);
         run_block($sformatf("random_%0d", i), pt, encrypt_model(k, pt), 1'b0);
      end

      k = rand_block();                  // One key, blocks back to back
      load_key("back_to_back", k);
      for (int i = 0; i < 6; i++) begin
         pt = rand_block();
         run_block($sformatf("back_to_back_%0d", i), pt, encrypt_model(k, pt), 1'b0);
      end

      for (int i = 0; i < 8; i++) begin
         k  = rand_block();
         pt = rand_block();
         load_key($sformatf("en_drop_%0d", i), k);
         run_block($sformatf("en_drop_%0d", i), pt, encrypt_model(k, pt), 1'b1);
      end

      if (n_checked == n_issued && exp_q.size() == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run($sformatf("only %0d of %0d blocks produced a dvld pulse",
                             n_checked, n_issued));
      end
   end

endmodule

// File: rtl/aes_enc_top.sv
// ----------------------------------------------------------
// Iterative AES-128 encryption core, top level
// Load key with krdy, data with drdy, ciphertext on dvld
// en low freezes the whole core
// ----------------------------------------------------------
module aes_enc_top (
   input  logic                CLK,
   input  logic                rst,
   input  logic                en,    // Global enable
   input  logic                krdy,  // Key strobe
   input  logic                drdy,  // Data strobe
   input  aes_pkg::aes_block_t kin,
   input  aes_pkg::aes_block_t din,
   output aes_pkg::aes_block_t dout,  // Ciphertext
   output logic                kvld,  // Key accepted
   output logic                dvld,  // Ciphertext valid
   output logic                bsy
);

   aes_ctrl_if ctrl_if ();

   // Round sequencer
   aes_round_ctrl ctrl_i (
      .CLK  (CLK),
      .rst  (rst),
      .en   (en),
      .krdy (krdy),
      .drdy (drdy),
      .kvld (kvld),
      .dvld (dvld),
      .bsy  (bsy),
      .ctrl (ctrl_if.ctrl)
   );

   // Datapath and key schedule
   aes_state_regs regs_i (
      .CLK  (CLK),
      .rst  (rst),
      .kin  (kin),
      .din  (din),
      .dout (dout),
      .regs (ctrl_if.regs)
   );

endmodule

// File: rtl/aes_state_regs.sv
// ----------------------------------------------------------
// State register bank of the AES-128 core
// Holds cipher key, round key and state, one round per advance
// The state register doubles as the ciphertext output
// ----------------------------------------------------------
module aes_state_regs (
   input  logic                CLK,
   input  logic                rst,
   input  aes_pkg::aes_block_t kin,
   input  aes_pkg::aes_block_t din,
   output aes_pkg::aes_block_t dout,
   aes_ctrl_if.regs            regs
);
   import aes_pkg::*;

   aes_block_t key;        // Cipher key
   aes_block_t rkey;       // Previous round key
   aes_block_t rkey_next;  // Key for the round being computed
   aes_state_u dat;
   aes_state_u dat_next;

   // ----------------------------------------------------------
   // Round datapath and key schedule
   // ----------------------------------------------------------
   aes_round round_i (
      .state       (dat),
      .round_key   (rkey_next),
      .final_round (regs.final_round),
      .next_state  (dat_next)
   );

   aes_key_step key_step_i (
      .key      (rkey),
      .rcon     (regs.rcon),
      .next_key (rkey_next)
   );

   // ----------------------------------------------------------
   // Key registers
   // ----------------------------------------------------------
   always_ff @(posedge CLK) begin
      if (regs.load_key) begin
         key <= kin;
      end
   end

   always_ff @(posedge CLK) begin
      if (regs.en) begin
         if (regs.load_key) begin
            rkey <= kin;
         end else if (regs.first_round) begin
            rkey <= key;                       // Restart schedule while idle
         end else begin
            rkey <= rkey_next;                 // Step on the fly
         end
      end
   end

   // State, also the result held for the host
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         dat <= '0;
      end else if (regs.load_data) begin
         dat <= din ^ key;                     // Initial AddRoundKey
      end else if (regs.en && regs.advance) begin
         dat <= dat_next;
      end
   end

   assign dout = dat;

   a_load_vs_advance: assert property (@(posedge CLK) disable iff (rst)
      !(regs.load_data && regs.advance))
      else $error("new block loaded during rounds");

endmodule

// File: rtl/aes_round_ctrl.sv
// ----------------------------------------------------------
// Round sequencer for the iterative AES-128 core
// One-hot round register, round constant and host status
// kvld/dvld are one-cycle pulses, bsy covers a whole block
// ----------------------------------------------------------
module aes_round_ctrl (
   input  logic     CLK,
   input  logic     rst,
   input  logic     en,
   input  logic     krdy,
   input  logic     drdy,
   output logic     kvld,
   output logic     dvld,
   output logic     bsy,
   aes_ctrl_if.ctrl ctrl
);
   import aes_pkg::*;

   logic [N_ROUNDS-1:0] rnd;      // Bit 0 means idle
   logic                final_q;  // Round ten in progress
   logic [BYTE_W-1:0]   rcon;
   logic                idle;

   assign idle = rnd[0];

   // ----------------------------------------------------------
   // Round register and round constant
   // ----------------------------------------------------------
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         rnd     <= N_ROUNDS'(1);
         final_q <= 1'b0;
         rcon    <= RCON_INIT;
      end else if (en) begin
         if (drdy || !idle) begin
            rnd <= {rnd[N_ROUNDS-2:0], rnd[N_ROUNDS-1]};  // Rotate, wraps back to idle
         end
         final_q <= rnd[N_ROUNDS-1];                     // Set for one cycle after round 9
         if (drdy) begin
            rcon <= RCON_INIT;
         end else if (!idle) begin
            rcon <= xtime(rcon);                         // Next rcon by doubling
         end
      end
   end

   // ----------------------------------------------------------
   // Host status
   // ----------------------------------------------------------
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         kvld <= 1'b0;
         dvld <= 1'b0;
         bsy  <= 1'b0;
      end else if (en) begin
         kvld <= krdy;                                   // Key ack next cycle
         dvld <= final_q;                                // Ciphertext just latched
         bsy  <= drdy | (|rnd[N_ROUNDS-1:1]) | final_q;
      end
   end

   // Commands to the state bank
   assign ctrl.load_key    = krdy & en;
   assign ctrl.load_data   = drdy & en;
   assign ctrl.advance     = ~idle | final_q;            // Rounds 1 to 10
   assign ctrl.first_round = idle;
   assign ctrl.final_round = final_q;
   assign ctrl.rcon        = rcon;
   assign ctrl.en          = en;

   // ----------------------------------------------------------
   // Protocol checks
   // ----------------------------------------------------------
   a_drdy_not_busy: assert property (@(posedge CLK) disable iff (rst)
      (en && drdy) |-> !bsy)
      else $error("drdy issued while core busy");

   a_rnd_onehot: assert property (@(posedge CLK) disable iff (rst)
      $onehot(rnd))
      else $error("round register lost one-hot");

   a_dvld_pulse: assert property (@(posedge CLK) disable iff (rst)
      (en && dvld) |=> !dvld)
      else $error("dvld high for two enabled cycles");

endmodule

// File: rtl/aes_key_step.sv
// ----------------------------------------------------------
// One step of the AES-128 key expansion, combinational
// Next round key from the current one and its round constant
// ----------------------------------------------------------
module aes_key_step (
   input  aes_pkg::aes_block_t        key,
   input  logic [aes_pkg::BYTE_W-1:0] rcon,
   output aes_pkg::aes_block_t        next_key
);
   import aes_pkg::*;

   logic [0:3][WORD_W-1:0] kw;            // Word 0 in the MSBs
   logic [0:3][BYTE_W-1:0] last_w;        // Last word by bytes
   logic [0:3][BYTE_W-1:0] sub_w;         // RotWord then SubWord
   logic [0:3][WORD_W-1:0] nw;

   assign kw     = key;
   assign last_w = kw[3];

   // RotWord folded into the S-box byte selection
   for (genvar i = 0; i < 4; i++) begin : g_sub
      aes_sbox sbox_i (
         .x (last_w[(i + 1) % 4]),
         .y (sub_w[i])
      );
   end

   // ----------------------------------------------------------
   // Rcon into top byte, then XOR chain across the words
   // ----------------------------------------------------------
   always_comb begin
      nw[0] = sub_w ^ {rcon, {(WORD_W - BYTE_W){1'b0}}} ^ kw[0];
      for (int j = 1; j < 4; j++) begin
         nw[j] = nw[j-1] ^ kw[j];
      end
   end

   assign next_key = nw;

endmodule

// File: rtl/aes_round.sv
// ----------------------------------------------------------
// One combinational AES encryption round
// SubBytes, ShiftRows, MixColumns and AddRoundKey in sequence
// final_round bypasses MixColumns for round ten
// ----------------------------------------------------------
module aes_round (
   input  aes_pkg::aes_state_u state,
   input  aes_pkg::aes_block_t round_key,
   input  logic                final_round,
   output aes_pkg::aes_state_u next_state
);
   import aes_pkg::*;

   logic [0:BLOCK_W/BYTE_W-1][BYTE_W-1:0] sub_b;   // SubBytes result
   aes_state_u                            shifted; // Written as bytes, read as columns
   aes_state_u                            mixed;

   // Column times {02 03 01 01} circulant
   function automatic logic [WORD_W-1:0] mix_column(input logic [WORD_W-1:0] c);
      logic [0:3][BYTE_W-1:0] a;
      logic [0:3][BYTE_W-1:0] d;
      logic [0:3][BYTE_W-1:0] m;
      a = c;
      for (int i = 0; i < 4; i++) begin
         d[i] = xtime(a[i]);                      // 2*a
      end
      for (int i = 0; i < 4; i++) begin
         m[i] = d[i] ^ d[(i + 1) % 4] ^ a[(i + 1) % 4] ^ a[(i + 2) % 4] ^ a[(i + 3) % 4];
      end
      return m;
   endfunction

   // ----------------------------------------------------------
   // SubBytes
   // ----------------------------------------------------------
   for (genvar i = 0; i < BLOCK_W / BYTE_W; i++) begin : g_sub
      aes_sbox sbox_i (
         .x (state.bytes[i]),
         .y (sub_b[i])
      );
   end

   // ----------------------------------------------------------
   // ShiftRows then MixColumns, row r rotates left by r
   // ----------------------------------------------------------
   always_comb begin
      for (int c = 0; c < BLOCK_W / WORD_W; c++) begin
         for (int r = 0; r < 4; r++) begin
            shifted.bytes[4*c + r] = sub_b[4*((c + r) % 4) + r];
         end
         mixed.col[c] = final_round ? shifted.col[c] : mix_column(shifted.col[c]);
      end
   end

   assign next_state = mixed ^ round_key;       // AddRoundKey

   // Round select must come from a reset controller
   always_comb begin
      a_final_known: assert final (!$isunknown(final_round))
         else $error("aes_round final_round is unknown");
   end

endmodule

// File: rtl/aes_sbox.sv
// ----------------------------------------------------------
// AES S-box on one byte, inversion done in GF((2^4)^2)
// Map in, invert through GF(2^4) and GF(2^2), map out, affine
// Purely combinational, instantiated per byte by round and key step
// ----------------------------------------------------------
module aes_sbox (
   input  logic [aes_pkg::BYTE_W-1:0] x,
   output logic [aes_pkg::BYTE_W-1:0] y
);
   import aes_pkg::*;

   logic [BYTE_W-1:0] x_cf;         // Input in composite basis
   logic [BYTE_W-1:0] y_cf;         // Inverse in composite basis
   logic [BYTE_W-1:0] y_inv;        // Inverse back in AES basis
   logic [3:0]        hi;
   logic [3:0]        lo;
   logic [3:0]        hl;
   logic [3:0]        n_inv;        // Inverse of the GF(2^4) norm

   // GF(2) matrix times vector, one parity per row
   function automatic logic [BYTE_W-1:0] bit_mat(
      input logic [BYTE_W-1:0][BYTE_W-1:0] m,
      input logic [BYTE_W-1:0]             v
   );
      logic [BYTE_W-1:0] r;
      for (int i = 0; i < BYTE_W; i++) begin
         r[i] = ^(m[i] & v);
      end
      return r;
   endfunction

   // ----------------------------------------------------------
   // Isomorphism into GF((2^4)^2)
   // ----------------------------------------------------------
   assign x_cf = bit_mat(ISO_M, x);
   assign hi   = x_cf[7:4];
   assign lo   = x_cf[3:0];
   assign hl   = hi ^ lo;

   // ----------------------------------------------------------
   // Inversion, (hi*y + lo)^-1 = (hi*y + hi+lo) / norm
   // ----------------------------------------------------------
   assign n_inv = gf4_inv(gf4_scale(gf4_sq(hi)) ^ gf4_mul(hl, lo));
   assign y_cf  = {gf4_mul(hi, n_inv), gf4_mul(hl, n_inv)};  // Zero maps to zero

   // ----------------------------------------------------------
   // Back to GF(2^8) and affine transform
   // ----------------------------------------------------------
   assign y_inv = bit_mat(ISO_INV_M, y_cf);
   assign y     = bit_mat(AFF_M, y_inv) ^ AFF_C;

endmodule

// File: rtl/aes_ctrl_if.sv
// ----------------------------------------------------------
// Command bundle from the round controller to the state bank
// ----------------------------------------------------------
interface aes_ctrl_if;
   import aes_pkg::*;

   logic              load_key;     // krdy qualified by en
   logic              load_data;    // drdy qualified by en
   logic              advance;      // State takes round output
   logic              first_round;  // Round key reloads from cipher key
   logic              final_round;  // Skip MixColumns
   logic [BYTE_W-1:0] rcon;         // Current round constant
   logic              en;           // Global enable

   modport ctrl (
      output load_key, load_data, advance, first_round, final_round, rcon, en
   );

   modport regs (
      input  load_key, load_data, advance, first_round, final_round, rcon, en
   );

endinterface

// File: rtl/aes_pkg.sv
// ----------------------------------------------------------
// Shared AES-128 definitions for the iterative encryption core
// Widths, the 128-bit state union, xtime and the GF(2^4) and
// GF(2^2) arithmetic behind the composite-field S-box
// ----------------------------------------------------------
package aes_pkg;

   // ----------------------------------------------------------
   // Widths and round count
   // ----------------------------------------------------------
   localparam int BLOCK_W  = 128;              // Block and key width
   localparam int WORD_W   = 32;               // One state column
   localparam int BYTE_W   = 8;
   localparam int N_ROUNDS = 10;               // Also one-hot round register width

   localparam logic [BYTE_W-1:0] RCON_INIT   = 8'h01;   // First round constant
   localparam logic [BYTE_W-1:0] GF_POLY_LOW = 8'h1B;   // x^4+x^3+x+1 part of AES poly

   // ----------------------------------------------------------
   // Composite field GF((2^4)^2) constants
   // ----------------------------------------------------------
   localparam logic [1:0] GF2_PHI    = 2'b10;  // GF(2^4) is GF(2^2)[z]/(z^2+z+phi)
   localparam logic [3:0] GF4_LAMBDA = 4'b1100; // GF(2^8) is GF(2^4)[y]/(y^2+y+lambda)

   // Bit matrices, entry i holds the input mask of output bit i
   localparam logic [BYTE_W-1:0][BYTE_W-1:0] ISO_M =      // GF(2^8) to composite
      {8'hA0, 8'hDE, 8'hAC, 8'hAE, 8'hC6, 8'h9E, 8'h52, 8'h43};
   localparam logic [BYTE_W-1:0][BYTE_W-1:0] ISO_INV_M =  // Composite back to GF(2^8)
      {8'hE2, 8'h44, 8'h62, 8'h76, 8'h3E, 8'h9E, 8'h30, 8'h75};
   localparam logic [BYTE_W-1:0][BYTE_W-1:0] AFF_M =      // S-box affine matrix
      {8'hF8, 8'h7C, 8'h3E, 8'h1F, 8'h8F, 8'hC7, 8'hE3, 8'hF1};
   localparam logic [BYTE_W-1:0] AFF_C = 8'h63;           // Affine constant

   // ----------------------------------------------------------
   // Types
   // ----------------------------------------------------------
   typedef logic [BLOCK_W-1:0] aes_block_t;

   typedef union packed {
      logic [0:BLOCK_W/WORD_W-1][WORD_W-1:0] col;   // Column 0 in the MSBs
      logic [0:BLOCK_W/BYTE_W-1][BYTE_W-1:0] bytes; // Byte 4*c+r is row r of column c
   } aes_state_u;

   // Multiply by x in GF(2^8)
   function automatic logic [BYTE_W-1:0] xtime(input logic [BYTE_W-1:0] b);
      return {b[BYTE_W-2:0], 1'b0} ^ (b[BYTE_W-1] ? GF_POLY_LOW : '0);
   endfunction

   // ----------------------------------------------------------
   // GF(2^2), normal poly w^2+w+1
   // ----------------------------------------------------------
   function automatic logic [1:0] gf2_mul(input logic [1:0] a, input logic [1:0] b);
      return {(a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]),
              (a[1] & b[1]) ^ (a[0] & b[0])};
   endfunction

   function automatic logic [1:0] gf2_sq(input logic [1:0] a);
      return {a[1], a[1] ^ a[0]};
   endfunction

   function automatic logic [1:0] gf2_scale(input logic [1:0] a);
      return gf2_mul(a, GF2_PHI);              // Times phi
   endfunction

   function automatic logic [1:0] gf2_inv(input logic [1:0] a);
      return gf2_sq(a);                        // a^-1 equals a^2 in GF(4)
   endfunction

   // ----------------------------------------------------------
   // GF(2^4) over GF(2^2), element {hi, lo} is hi*z + lo
   // ----------------------------------------------------------
   function automatic logic [3:0] gf4_mul(input logic [3:0] a, input logic [3:0] b);
      logic [1:0] hh;
      hh = gf2_mul(a[3:2], b[3:2]);
      return {hh ^ gf2_mul(a[3:2], b[1:0]) ^ gf2_mul(a[1:0], b[3:2]),
              gf2_scale(hh) ^ gf2_mul(a[1:0], b[1:0])};
   endfunction

   function automatic logic [3:0] gf4_sq(input logic [3:0] a);
      logic [1:0] h;
      h = gf2_sq(a[3:2]);
      return {h, gf2_scale(h) ^ gf2_sq(a[1:0])};
   endfunction

   function automatic logic [3:0] gf4_scale(input logic [3:0] a);
      return gf4_mul(a, GF4_LAMBDA);           // Times lambda
   endfunction

   function automatic logic [3:0] gf4_inv(input logic [3:0] a);
      logic [1:0] s;
      logic [1:0] n_inv;
      s     = a[3:2] ^ a[1:0];
      n_inv = gf2_inv(gf2_scale(gf2_sq(a[3:2])) ^ gf2_mul(s, a[1:0])); // Norm inverse
      return {gf2_mul(a[3:2], n_inv), gf2_mul(s, n_inv)};
   endfunction

endpackage
